// ==== src/atop_filter_pkg.sv ====
`default_nettype none

package atop_filter_pkg;

  // AXI field widths
  localparam int unsigned IdWidth = 4;
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned LenWidth = 8;
  // One strobe bit per data byte
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Response codes on B and R
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Operation kind, found in aw_atop[5:4]
  localparam logic [1:0] ATOP_NONE = 2'b00;
  localparam logic [1:0] ATOP_STORE = 2'b01;
  localparam logic [1:0] ATOP_LOAD = 2'b10;
  localparam logic [1:0] ATOP_SWAP_CMP = 2'b11;

  // Field view of aw_atop
  typedef struct packed {
    logic [1:0] kind;
    // Endianness of the arithmetic, big endian when set
    logic       endian;
    // Operation code within the kind
    logic [2:0] op;
  } atop_fields_t;

  // aw_atop, seen as one word or split into its fields
  typedef union packed {
    logic [5:0]   raw;
    atop_fields_t fields;
  } atop_u;

endpackage

`default_nettype wire

// ==== src/atop_cmd_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Command for one injected SLVERR read burst
interface atop_cmd_if
  import atop_filter_pkg::*;
();

  logic                valid;
  logic                ready;
  logic [IdWidth-1:0]  id;
  logic [LenWidth-1:0] len;
  // Command held or burst still going out on R
  logic                pending;

  modport producer (output valid, id, len, input ready, pending);

  modport consumer (input valid, id, len, output ready, pending);

endinterface

`default_nettype wire

// ==== src/atop_write_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module atop_write_fsm
  import atop_filter_pkg::*;
#(
  parameter int unsigned MaxWriteTxns = 4,
  localparam int unsigned CntWidth = $clog2(MaxWriteTxns + 1)
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Upstream write channels
  input  logic                slv_aw_valid_i,
  input  logic [IdWidth-1:0]  slv_aw_id_i,
  input  logic [LenWidth-1:0] slv_aw_len_i,
  input  atop_u               slv_aw_atop_i,
  output logic                slv_aw_ready_o,
  input  logic                slv_w_valid_i,
  input  logic                slv_w_last_i,
  output logic                slv_w_ready_o,
  input  logic                slv_b_ready_i,
  output logic                slv_b_valid_o,
  output logic [IdWidth-1:0]  slv_b_id_o,
  output logic [1:0]          slv_b_resp_o,
  // Downstream handshakes
  output logic                mst_aw_valid_o,
  input  logic                mst_aw_ready_i,
  output logic                mst_w_valid_o,
  input  logic                mst_w_ready_i,
  input  logic                mst_b_valid_i,
  input  logic [IdWidth-1:0]  mst_b_id_i,
  input  logic [1:0]          mst_b_resp_i,
  output logic                mst_b_ready_o,
  // Outstanding downstream write bursts
  input  logic [CntWidth-1:0] wr_count_i,
  atop_cmd_if.producer        cmd
);

  localparam logic [CntWidth-1:0] MaxCnt = CntWidth'(MaxWriteTxns);

  typedef enum logic [2:0] {
    PASS,
    BLOCK_AW,
    ABSORB_W,
    INJECT_B,
    WAIT_R
  } state_e;

  state_e             state_q, state_d;
  logic [IdWidth-1:0] id_q;
  logic               aw_atomic;
  logic               w_last_beat;

  // Any nonzero atop word marks an atomic operation
  assign aw_atomic = slv_aw_valid_i && (slv_aw_atop_i.raw != '0);
  assign w_last_beat = slv_w_valid_i && slv_w_last_i;

  // Read command always describes the AW on the slave port
  assign cmd.id = slv_aw_id_i;
  assign cmd.len = slv_aw_len_i;

  always_comb begin
    // No AW or W handshake unless a state allows one
    mst_aw_valid_o = 1'b0;
    slv_aw_ready_o = 1'b0;
    mst_w_valid_o = 1'b0;
    slv_w_ready_o = 1'b0;
    // B from memory passes by default
    mst_b_ready_o = slv_b_ready_i;
    slv_b_valid_o = mst_b_valid_i;
    slv_b_id_o = mst_b_id_i;
    slv_b_resp_o = mst_b_resp_i;
    cmd.valid = 1'b0;
    state_d = state_q;

    unique case (state_q)
      PASS: begin
        // AW passes until the outstanding limit is reached
        if (wr_count_i < MaxCnt) begin
          mst_aw_valid_o = slv_aw_valid_i;
          slv_aw_ready_o = mst_aw_ready_i;
        end
        // W only follows an AW that is already downstream
        if (wr_count_i != '0) begin
          mst_w_valid_o = slv_w_valid_i;
          slv_w_ready_o = mst_w_ready_i;
        end
        if (aw_atomic) begin
          // Atomic AW never reaches memory
          mst_aw_valid_o = 1'b0;
          slv_aw_ready_o = cmd.ready;
          if (cmd.ready) begin
            // Atomic stores get a B only
            cmd.valid = (slv_aw_atop_i.fields.kind != ATOP_STORE);
            if (wr_count_i != '0) begin
              state_d = BLOCK_AW;
            end else begin
              // Nothing outstanding, so these W beats belong to the ATOP
              mst_w_valid_o = 1'b0;
              slv_w_ready_o = 1'b1;
              state_d = w_last_beat ? INJECT_B : ABSORB_W;
            end
          end
        end
      end

      BLOCK_AW: begin
        // Drain W of the earlier bursts first
        if (wr_count_i != '0) begin
          mst_w_valid_o = slv_w_valid_i;
          slv_w_ready_o = mst_w_ready_i;
        end else begin
          slv_w_ready_o = 1'b1;
          state_d = w_last_beat ? INJECT_B : ABSORB_W;
        end
      end

      ABSORB_W: begin
        slv_w_ready_o = 1'b1;
        if (w_last_beat) begin
          state_d = INJECT_B;
        end
      end

      INJECT_B: begin
        // Memory B waits while the error response goes out
        mst_b_ready_o = 1'b0;
        slv_b_valid_o = 1'b1;
        slv_b_id_o = id_q;
        slv_b_resp_o = RESP_SLVERR;
        if (slv_b_ready_i) begin
          state_d = cmd.pending ? WAIT_R : PASS;
        end
      end

      WAIT_R: begin
        // Injected R burst must finish before the next ATOP
        if (!cmd.pending) begin
          state_d = PASS;
        end
      end

      default: state_d = PASS;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PASS;
    end else begin
      state_q <= state_d;
    end
  end

  // ID of the absorbed AW, for the injected B
  always_ff @(posedge clk_i) begin
    if (aw_atomic && slv_aw_ready_o) begin
      id_q <= slv_aw_id_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/atop_burst_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module atop_burst_counter #(
  parameter int unsigned MaxWriteTxns = 4,
  localparam int unsigned CntWidth = $clog2(MaxWriteTxns + 1)
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Downstream AW handshake
  input  logic                aw_fire_i,
  // Downstream handshake of a last W beat
  input  logic                w_last_fire_i,
  output logic [CntWidth-1:0] count_o
);

  // Both events together leave the count unchanged
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_o <= '0;
    end else begin
      unique case ({aw_fire_i, w_last_fire_i})
        2'b10: count_o <= count_o + 1'b1;
        2'b01: count_o <= count_o - 1'b1;
        default: count_o <= count_o;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/atop_r_injector.sv ====
`timescale 1ns/1ns
`default_nettype none

module atop_r_injector
  import atop_filter_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // R from memory
  input  logic                 mst_r_valid_i,
  input  logic [IdWidth-1:0]   mst_r_id_i,
  input  logic [DataWidth-1:0] mst_r_data_i,
  input  logic [1:0]           mst_r_resp_i,
  input  logic                 mst_r_last_i,
  output logic                 mst_r_ready_o,
  // R toward the master
  input  logic                 slv_r_ready_i,
  output logic                 slv_r_valid_o,
  output logic [IdWidth-1:0]   slv_r_id_o,
  output logic [DataWidth-1:0] slv_r_data_o,
  output logic [1:0]           slv_r_resp_o,
  output logic                 slv_r_last_o,
  atop_cmd_if.consumer         cmd
);

  // Full command register doubles as the inject state
  logic                full_q;
  logic [IdWidth-1:0]  id_q;
  logic [LenWidth-1:0] len_q;
  logic [LenWidth-1:0] beat_q;
  logic                push;
  logic                final_beat;

  assign cmd.ready = !full_q;
  assign cmd.pending = full_q;
  assign push = cmd.valid && !full_q;
  assign final_beat = (beat_q == len_q);

  always_comb begin
    if (full_q) begin
      // Error beats with zero data, memory R stalled
      mst_r_ready_o = 1'b0;
      slv_r_valid_o = 1'b1;
      slv_r_id_o = id_q;
      slv_r_data_o = '0;
      slv_r_resp_o = RESP_SLVERR;
      slv_r_last_o = final_beat;
    end else begin
      mst_r_ready_o = slv_r_ready_i;
      slv_r_valid_o = mst_r_valid_i;
      slv_r_id_o = mst_r_id_i;
      slv_r_data_o = mst_r_data_i;
      slv_r_resp_o = mst_r_resp_i;
      slv_r_last_o = mst_r_last_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
      beat_q <= '0;
    end else if (push) begin
      full_q <= 1'b1;
      beat_q <= '0;
    end else if (full_q && slv_r_ready_i) begin
      // Final beat taken frees the register
      if (final_beat) begin
        full_q <= 1'b0;
      end else begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_q <= cmd.id;
      len_q <= cmd.len;
    end
  end

endmodule

`default_nettype wire

// ==== src/atop_mem_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module atop_mem_slave
  import atop_filter_pkg::*;
#(
  parameter int unsigned MemWords = 256
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 aw_valid_i,
  input  logic [IdWidth-1:0]   aw_id_i,
  input  logic [AddrWidth-1:0] aw_addr_i,
  input  logic [LenWidth-1:0]  aw_len_i,
  output logic                 aw_ready_o,
  input  logic                 w_valid_i,
  input  logic [DataWidth-1:0] w_data_i,
  input  logic [StrbWidth-1:0] w_strb_i,
  input  logic                 w_last_i,
  output logic                 w_ready_o,
  input  logic                 b_ready_i,
  output logic                 b_valid_o,
  output logic [IdWidth-1:0]   b_id_o,
  output logic [1:0]           b_resp_o,
  input  logic                 ar_valid_i,
  input  logic [IdWidth-1:0]   ar_id_i,
  input  logic [AddrWidth-1:0] ar_addr_i,
  input  logic [LenWidth-1:0]  ar_len_i,
  output logic                 ar_ready_o,
  input  logic                 r_ready_i,
  output logic                 r_valid_o,
  output logic [IdWidth-1:0]   r_id_o,
  output logic [DataWidth-1:0] r_data_o,
  output logic [1:0]           r_resp_o,
  output logic                 r_last_o
);

  localparam int unsigned IdxWidth = $clog2(MemWords);
  localparam int unsigned ByteOffs = $clog2(StrbWidth);

  logic [DataWidth-1:0] mem_q [MemWords];

  // Write side, one burst plus its B at a time
  logic                w_busy_q;
  logic                b_valid_q;
  logic [IdxWidth-1:0] w_idx_q;
  logic [LenWidth-1:0] w_cnt_q;
  logic [IdWidth-1:0]  w_id_q;
  // Read side
  logic                r_busy_q;
  logic [IdxWidth-1:0] r_idx_q;
  logic [LenWidth-1:0] r_cnt_q;
  logic [IdWidth-1:0]  r_id_q;

  logic aw_fire, w_fire, w_done, ar_fire, r_fire;

  assign aw_ready_o = aw_valid_i && !w_busy_q && !b_valid_q;
  assign w_ready_o = w_busy_q;
  assign ar_ready_o = ar_valid_i && !r_busy_q;

  assign aw_fire = aw_valid_i && aw_ready_o;
  assign w_fire = w_valid_i && w_ready_o;
  // Burst closes on last, or when the AW beat count runs out
  assign w_done = w_fire && (w_last_i || (w_cnt_q == '0));
  assign ar_fire = ar_valid_i && ar_ready_o;
  assign r_fire = r_valid_o && r_ready_i;

  assign b_valid_o = b_valid_q;
  assign b_id_o = w_id_q;
  assign b_resp_o = RESP_OKAY;

  // First beat is ready the cycle after AR
  assign r_valid_o = r_busy_q;
  assign r_id_o = r_id_q;
  assign r_data_o = mem_q[r_idx_q];
  assign r_resp_o = RESP_OKAY;
  assign r_last_o = (r_cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_busy_q <= 1'b0;
      b_valid_q <= 1'b0;
      r_busy_q <= 1'b0;
    end else begin
      if (aw_fire) begin
        w_busy_q <= 1'b1;
      end else if (w_done) begin
        w_busy_q <= 1'b0;
      end
      if (w_done) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0;
      end
      if (ar_fire) begin
        r_busy_q <= 1'b1;
      end else if (r_fire && r_last_o) begin
        r_busy_q <= 1'b0;
      end
    end
  end

  // Word index wraps modulo the memory depth
  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      w_idx_q <= aw_addr_i[ByteOffs +: IdxWidth];
      w_cnt_q <= aw_len_i;
      w_id_q <= aw_id_i;
    end else if (w_fire) begin
      for (int i = 0; i < StrbWidth; i++) begin
        if (w_strb_i[i]) begin
          mem_q[w_idx_q][8*i +: 8] <= w_data_i[8*i +: 8];
        end
      end
      w_idx_q <= w_idx_q + 1'b1;
      w_cnt_q <= w_cnt_q - 1'b1;
    end
    if (ar_fire) begin
      r_idx_q <= ar_addr_i[ByteOffs +: IdxWidth];
      r_cnt_q <= ar_len_i;
      r_id_q <= ar_id_i;
    end else if (r_fire) begin
      r_idx_q <= r_idx_q + 1'b1;
      r_cnt_q <= r_cnt_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/atop_filter_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module atop_filter_top
  import atop_filter_pkg::*;
#(
  parameter int unsigned MaxWriteTxns = 4,
  parameter int unsigned MemWords = 256
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 slv_aw_valid_i,
  output logic                 slv_aw_ready_o,
  input  logic [IdWidth-1:0]   slv_aw_id_i,
  input  logic [AddrWidth-1:0] slv_aw_addr_i,
  input  logic [LenWidth-1:0]  slv_aw_len_i,
  input  logic [5:0]           slv_aw_atop_i,
  input  logic                 slv_w_valid_i,
  output logic                 slv_w_ready_o,
  input  logic [DataWidth-1:0] slv_w_data_i,
  input  logic [StrbWidth-1:0] slv_w_strb_i,
  input  logic                 slv_w_last_i,
  output logic                 slv_b_valid_o,
  input  logic                 slv_b_ready_i,
  output logic [IdWidth-1:0]   slv_b_id_o,
  output logic [1:0]           slv_b_resp_o,
  input  logic                 slv_ar_valid_i,
  output logic                 slv_ar_ready_o,
  input  logic [IdWidth-1:0]   slv_ar_id_i,
  input  logic [AddrWidth-1:0] slv_ar_addr_i,
  input  logic [LenWidth-1:0]  slv_ar_len_i,
  output logic                 slv_r_valid_o,
  input  logic                 slv_r_ready_i,
  output logic [IdWidth-1:0]   slv_r_id_o,
  output logic [DataWidth-1:0] slv_r_data_o,
  output logic [1:0]           slv_r_resp_o,
  output logic                 slv_r_last_o
);

  localparam int unsigned CntWidth = $clog2(MaxWriteTxns + 1);

  // Downstream channels toward memory
  logic                 mst_aw_valid, mst_aw_ready;
  logic [IdWidth-1:0]   mst_aw_id;
  logic [AddrWidth-1:0] mst_aw_addr;
  logic [LenWidth-1:0]  mst_aw_len;
  logic                 mst_w_valid, mst_w_ready, mst_w_last;
  logic [DataWidth-1:0] mst_w_data;
  logic [StrbWidth-1:0] mst_w_strb;
  logic                 mst_b_valid, mst_b_ready;
  logic [IdWidth-1:0]   mst_b_id;
  logic [1:0]           mst_b_resp;
  logic                 mst_ar_valid, mst_ar_ready;
  logic [IdWidth-1:0]   mst_ar_id;
  logic [AddrWidth-1:0] mst_ar_addr;
  logic [LenWidth-1:0]  mst_ar_len;
  logic                 mst_r_valid, mst_r_ready, mst_r_last;
  logic [IdWidth-1:0]   mst_r_id;
  logic [DataWidth-1:0] mst_r_data;
  logic [1:0]           mst_r_resp;

  logic [CntWidth-1:0] wr_count;
  logic                aw_fire;
  logic                w_last_fire;

  // AW and W payload and the whole AR channel go straight through
  assign mst_aw_id = slv_aw_id_i;
  assign mst_aw_addr = slv_aw_addr_i;
  assign mst_aw_len = slv_aw_len_i;
  assign mst_w_data = slv_w_data_i;
  assign mst_w_strb = slv_w_strb_i;
  assign mst_w_last = slv_w_last_i;
  assign mst_ar_valid = slv_ar_valid_i;
  assign mst_ar_id = slv_ar_id_i;
  assign mst_ar_addr = slv_ar_addr_i;
  assign mst_ar_len = slv_ar_len_i;
  assign slv_ar_ready_o = mst_ar_ready;

  assign aw_fire = mst_aw_valid && mst_aw_ready;
  assign w_last_fire = mst_w_valid && mst_w_ready && mst_w_last;

  atop_cmd_if cmd_if ();

  atop_write_fsm #(
    .MaxWriteTxns (MaxWriteTxns)
  ) u_write_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_id_i    (slv_aw_id_i),
    .slv_aw_len_i   (slv_aw_len_i),
    .slv_aw_atop_i  (slv_aw_atop_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .slv_w_valid_i  (slv_w_valid_i),
    .slv_w_last_i   (slv_w_last_i),
    .slv_w_ready_o  (slv_w_ready_o),
    .slv_b_ready_i  (slv_b_ready_i),
    .slv_b_valid_o  (slv_b_valid_o),
    .slv_b_id_o     (slv_b_id_o),
    .slv_b_resp_o   (slv_b_resp_o),
    .mst_aw_valid_o (mst_aw_valid),
    .mst_aw_ready_i (mst_aw_ready),
    .mst_w_valid_o  (mst_w_valid),
    .mst_w_ready_i  (mst_w_ready),
    .mst_b_valid_i  (mst_b_valid),
    .mst_b_id_i     (mst_b_id),
    .mst_b_resp_i   (mst_b_resp),
    .mst_b_ready_o  (mst_b_ready),
    .wr_count_i     (wr_count),
    .cmd            (cmd_if.producer)
  );

  atop_burst_counter #(
    .MaxWriteTxns (MaxWriteTxns)
  ) u_burst_counter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .aw_fire_i     (aw_fire),
    .w_last_fire_i (w_last_fire),
    .count_o       (wr_count)
  );

  atop_r_injector u_r_injector (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mst_r_valid_i (mst_r_valid),
    .mst_r_id_i    (mst_r_id),
    .mst_r_data_i  (mst_r_data),
    .mst_r_resp_i  (mst_r_resp),
    .mst_r_last_i  (mst_r_last),
    .mst_r_ready_o (mst_r_ready),
    .slv_r_ready_i (slv_r_ready_i),
    .slv_r_valid_o (slv_r_valid_o),
    .slv_r_id_o    (slv_r_id_o),
    .slv_r_data_o  (slv_r_data_o),
    .slv_r_resp_o  (slv_r_resp_o),
    .slv_r_last_o  (slv_r_last_o),
    .cmd           (cmd_if.consumer)
  );

  atop_mem_slave #(
    .MemWords (MemWords)
  ) u_mem (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .aw_valid_i (mst_aw_valid),
    .aw_id_i    (mst_aw_id),
    .aw_addr_i  (mst_aw_addr),
    .aw_len_i   (mst_aw_len),
    .aw_ready_o (mst_aw_ready),
    .w_valid_i  (mst_w_valid),
    .w_data_i   (mst_w_data),
    .w_strb_i   (mst_w_strb),
    .w_last_i   (mst_w_last),
    .w_ready_o  (mst_w_ready),
    .b_ready_i  (mst_b_ready),
    .b_valid_o  (mst_b_valid),
    .b_id_o     (mst_b_id),
    .b_resp_o   (mst_b_resp),
    .ar_valid_i (mst_ar_valid),
    .ar_id_i    (mst_ar_id),
    .ar_addr_i  (mst_ar_addr),
    .ar_len_i   (mst_ar_len),
    .ar_ready_o (mst_ar_ready),
    .r_ready_i  (mst_r_ready),
    .r_valid_o  (mst_r_valid),
    .r_id_o     (mst_r_id),
    .r_data_o   (mst_r_data),
    .r_resp_o   (mst_r_resp),
    .r_last_o   (mst_r_last)
  );

endmodule

`default_nettype wire

// ==== bench/atop_filter_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module atop_filter_sva #(
  parameter int unsigned CntWidth = 3
) (
  input wire logic                clk_i,
  input wire logic                rst_ni,
  input wire logic [5:0]          slv_aw_atop_i,
  input wire logic                mst_aw_valid_i,
  input wire logic                mst_aw_ready_i,
  input wire logic                mst_w_valid_i,
  input wire logic                mst_w_ready_i,
  input wire logic [CntWidth-1:0] wr_count_i,
  input wire logic [2:0]          fsm_state_i,
  input wire logic                slv_b_valid_i,
  input wire logic                slv_b_ready_i,
  input wire logic                slv_r_valid_i,
  input wire logic                slv_r_ready_i
);

  // Encoding of ABSORB_W in the write FSM
  localparam logic [2:0] AbsorbState = 3'd2;

  // Atomic AW never shows up downstream
  no_atomic_aw: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_aw_valid_i |-> (slv_aw_atop_i == 6'd0))
    else $error("atomic AW reached the memory");

  // Absorbed beats leave the memory untouched
  absorb_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fsm_state_i == AbsorbState) |-> !(mst_w_valid_i && mst_w_ready_i)
                                     && !(mst_aw_valid_i && mst_aw_ready_i))
    else $error("memory write handshake during absorb");

  b_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv_b_valid_i && !slv_b_ready_i |=> slv_b_valid_i)
    else $error("B valid dropped before ready");

  r_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv_r_valid_i && !slv_r_ready_i |=> slv_r_valid_i)
    else $error("R valid dropped before ready");

  // W goes down only behind an accepted AW
  w_needs_aw: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_w_valid_i |-> (wr_count_i != '0))
    else $error("memory W valid with no burst outstanding");

endmodule

bind atop_filter_top atop_filter_sva #(.CntWidth(CntWidth)) i_sva (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .slv_aw_atop_i  (slv_aw_atop_i),
  .mst_aw_valid_i (mst_aw_valid),
  .mst_aw_ready_i (mst_aw_ready),
  .mst_w_valid_i  (mst_w_valid),
  .mst_w_ready_i  (mst_w_ready),
  .wr_count_i     (wr_count),
  .fsm_state_i    (u_write_fsm.state_q),
  .slv_b_valid_i  (slv_b_valid_o),
  .slv_b_ready_i  (slv_b_ready_i),
  .slv_r_valid_i  (slv_r_valid_o),
  .slv_r_ready_i  (slv_r_ready_i)
);

`default_nettype wire

// ==== bench/atop_filter_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module atop_filter_tb
  import atop_filter_pkg::*;
();

  localparam int unsigned ClkPeriod = 10;
  localparam int unsigned MaxWriteTxns = 4;
  localparam int unsigned MemWords = 256;
  localparam int unsigned IdxWidth = $clog2(MemWords);
  localparam int unsigned MaxBeats = 8;
  localparam int unsigned NumRandom = 200;
  // Fill bursts plus directed and random transactions with their reads
  localparam int unsigned NumTxns = 2 * (MemWords / MaxBeats + 16 + NumRandom);
  localparam int unsigned WatchdogCycles = NumTxns * MaxBeats * 4;
  localparam int unsigned RWidth = IdWidth + DataWidth + 3;

  logic clk_i, rst_ni;
  logic slv_aw_valid_i, slv_aw_ready_o;
  logic [IdWidth-1:0] slv_aw_id_i;
  logic [AddrWidth-1:0] slv_aw_addr_i;
  logic [LenWidth-1:0] slv_aw_len_i;
  logic [5:0] slv_aw_atop_i;
  logic slv_w_valid_i, slv_w_ready_o, slv_w_last_i;
  logic [DataWidth-1:0] slv_w_data_i;
  logic [StrbWidth-1:0] slv_w_strb_i;
  logic slv_b_valid_o, slv_b_ready_i;
  logic [IdWidth-1:0] slv_b_id_o;
  logic [1:0] slv_b_resp_o;
  logic slv_ar_valid_i, slv_ar_ready_o;
  logic [IdWidth-1:0] slv_ar_id_i;
  logic [AddrWidth-1:0] slv_ar_addr_i;
  logic [LenWidth-1:0] slv_ar_len_i;
  logic slv_r_valid_o, slv_r_ready_i, slv_r_last_o;
  logic [IdWidth-1:0] slv_r_id_o;
  logic [DataWidth-1:0] slv_r_data_o;
  logic [1:0] slv_r_resp_o;

  // Model memory and expected responses in arrival order
  logic [DataWidth-1:0] model_mem [MemWords];
  logic [IdWidth+1:0] exp_b [$];
  logic [RWidth-1:0] exp_r [$];
  logic [DataWidth-1:0] burst_data [MaxBeats];
  logic [StrbWidth-1:0] burst_strb [MaxBeats];
  logic [IdWidth+1:0] b_exp;
  logic [RWidth-1:0] r_exp;
  logic [31:0] stim_seed = 32'h1d4f;
  logic [31:0] stall_seed = 32'h1d4f;
  logic stall_en;
  string test_name;

  atop_filter_top #(
    .MaxWriteTxns (MaxWriteTxns),
    .MemWords     (MemWords)
  ) i_dut (.*);

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper halves only since the low LCG bits repeat too soon
  function logic [31:0] rand_word();
    logic [15:0] hi;
    stim_seed = lcg_step(stim_seed);
    hi = stim_seed[31:16];
    stim_seed = lcg_step(stim_seed);
    return {hi, stim_seed[31:16]};
  endfunction

  // Start pattern with every word distinct
  function automatic logic [DataWidth-1:0] fill_word(input int unsigned idx);
    logic [7:0] a;
    a = idx[7:0];
    return {~a, a ^ 8'h5a, a, a ^ 8'hc3};
  endfunction

  // Expected B of a write that updates the model only for plain writes
  function logic [IdWidth+1:0] ref_write(input logic [IdWidth-1:0] id,
                                         input logic [IdxWidth-1:0] word,
                                         input int unsigned len, input logic atomic);
    logic [IdxWidth-1:0] idx;
    idx = word;
    if (atomic) begin
      return {id, RESP_SLVERR};
    end
    for (int unsigned b = 0; b <= len; b++) begin
      for (int i = 0; i < StrbWidth; i++) begin
        if (burst_strb[b][i]) begin
          model_mem[idx][8*i +: 8] = burst_data[b][8*i +: 8];
        end
      end
      idx = idx + 1'b1;
    end
    return {id, RESP_OKAY};
  endfunction

  // Expected R beat as id, data, resp, last
  function logic [RWidth-1:0] ref_read_beat(input logic [IdWidth-1:0] id,
                                            input logic [IdxWidth-1:0] word,
                                            input int unsigned beat, input int unsigned len,
                                            input logic injected);
    logic [IdxWidth-1:0] idx;
    idx = IdxWidth'(word + beat);
    if (injected) begin
      return {id, {DataWidth{1'b0}}, RESP_SLVERR, beat == len};
    end
    return {id, model_mem[idx], RESP_OKAY, beat == len};
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  task automatic prepare_burst();
    logic [31:0] r;
    for (int b = 0; b < MaxBeats; b++) begin
      burst_data[b] = rand_word();
      r = rand_word();
      burst_strb[b] = r[31:28];
    end
  endtask

  task automatic send_aw(input logic [IdWidth-1:0] id, input logic [IdxWidth-1:0] word,
                         input int unsigned len, input logic [5:0] atop);
    slv_aw_valid_i <= 1'b1;
    slv_aw_id_i <= id;
    slv_aw_addr_i <= AddrWidth'({word, 2'b00});
    slv_aw_len_i <= LenWidth'(len);
    slv_aw_atop_i <= atop;
    do @(posedge clk_i); while (!slv_aw_ready_o);
    slv_aw_valid_i <= 1'b0;
  endtask

  task automatic send_w(input int unsigned len);
    for (int unsigned b = 0; b <= len; b++) begin
      slv_w_valid_i <= 1'b1;
      slv_w_data_i <= burst_data[b];
      slv_w_strb_i <= burst_strb[b];
      slv_w_last_i <= (b == len);
      do @(posedge clk_i); while (!slv_w_ready_o);
    end
    slv_w_valid_i <= 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_b.size() != 0 || exp_r.size() != 0) begin
      @(posedge clk_i);
    end
  endtask

  // Queues the expected B and any injected R beats
  task automatic expect_write(input logic [IdWidth-1:0] id, input logic [IdxWidth-1:0] word,
                              input int unsigned len, input logic [5:0] atop);
    exp_b.push_back(ref_write(id, word, len, atop != 6'd0));
    if (atop != 6'd0 && atop[5:4] != ATOP_STORE) begin
      for (int unsigned b = 0; b <= len; b++) begin
        exp_r.push_back(ref_read_beat(id, word, b, len, 1'b1));
      end
    end
  endtask

  task automatic write_txn(input logic [IdWidth-1:0] id, input logic [IdxWidth-1:0] word,
                           input int unsigned len, input logic [5:0] atop);
    expect_write(id, word, len, atop);
    send_aw(id, word, len, atop);
    send_w(len);
    wait_idle();
  endtask

  task automatic read_txn(input logic [IdWidth-1:0] id, input logic [IdxWidth-1:0] word,
                          input int unsigned len);
    for (int unsigned b = 0; b <= len; b++) begin
      exp_r.push_back(ref_read_beat(id, word, b, len, 1'b0));
    end
    slv_ar_valid_i <= 1'b1;
    slv_ar_id_i <= id;
    slv_ar_addr_i <= AddrWidth'({word, 2'b00});
    slv_ar_len_i <= LenWidth'(len);
    do @(posedge clk_i); while (!slv_ar_ready_o);
    slv_ar_valid_i <= 1'b0;
    wait_idle();
  endtask

  function automatic logic [5:0] make_atop(input logic [1:0] kind, input logic [3:0] r);
    return (kind == ATOP_NONE) ? 6'd0 : {kind, r};
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Random back-pressure on B and R
  always @(posedge clk_i) begin
    stall_seed = lcg_step(stall_seed);
    slv_b_ready_i <= !stall_en || (stall_seed[25:24] != 2'b00);
    slv_r_ready_i <= !stall_en || (stall_seed[29:28] != 2'b00);
  end

  // Compare every B and R handshake with the head of its queue
  always @(posedge clk_i) begin
    if (rst_ni && slv_b_valid_o && slv_b_ready_i) begin
      if (exp_b.size() == 0) begin
        stop_run("B response arrived when none was expected");
      end else begin
        b_exp = exp_b.pop_front();
        assert ({slv_b_id_o, slv_b_resp_o} == b_exp) else
          stop_run($sformatf("FAILED %s expected %h actual %h", test_name, b_exp,
                             {slv_b_id_o, slv_b_resp_o}));
      end
    end
    if (rst_ni && slv_r_valid_o && slv_r_ready_i) begin
      if (exp_r.size() == 0) begin
        stop_run("R beat arrived when none was expected");
      end else begin
        r_exp = exp_r.pop_front();
        assert ({slv_r_id_o, slv_r_data_o, slv_r_resp_o, slv_r_last_o} == r_exp) else
          stop_run($sformatf("FAILED %s expected %h actual %h", test_name, r_exp,
                             {slv_r_id_o, slv_r_data_o, slv_r_resp_o, slv_r_last_o}));
      end
    end
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    stop_run("Timeout: the DUT stopped answering");
  end

  initial begin
    logic [31:0] r;
    logic [IdxWidth-1:0] word;
    int unsigned len;
    logic [5:0] atop;
    rst_ni = 1'b0;
    stall_en = 1'b0;
    slv_aw_valid_i = 1'b0;
    slv_aw_id_i = '0;
    slv_aw_addr_i = '0;
    slv_aw_len_i = '0;
    slv_aw_atop_i = '0;
    slv_w_valid_i = 1'b0;
    slv_w_data_i = '0;
    slv_w_strb_i = '0;
    slv_w_last_i = 1'b0;
    slv_b_ready_i = 1'b1;
    slv_ar_valid_i = 1'b0;
    slv_ar_id_i = '0;
    slv_ar_addr_i = '0;
    slv_ar_len_i = '0;
    slv_r_ready_i = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    // Whole memory gets a known pattern first
    test_name = "fill";
    for (int unsigned w = 0; w < MemWords; w += MaxBeats) begin
      for (int unsigned b = 0; b < MaxBeats; b++) begin
        burst_data[b] = fill_word(w + b);
        burst_strb[b] = '1;
      end
      write_txn('0, IdxWidth'(w), MaxBeats - 1, 6'd0);
    end

    test_name = "normal_write";
    r = rand_word();
    prepare_burst();
    write_txn(r[27:24], r[23:16], r[31:29], 6'd0);
    read_txn(r[11:8], r[23:16], r[31:29]);

    test_name = "atomic_store";
    r = rand_word();
    prepare_burst();
    write_txn(r[27:24], r[23:16], r[31:29], make_atop(ATOP_STORE, r[3:0]));
    read_txn(r[11:8], r[23:16], r[31:29]);

    test_name = "atomic_load_swap";
    for (int k = 2; k < 4; k++) begin
      r = rand_word();
      prepare_burst();
      write_txn(r[27:24], r[23:16], r[31:29], make_atop(k[1:0], r[3:0]));
      read_txn(r[11:8], r[23:16], r[31:29]);
    end

    // Atomic AW queued behind a plain AW whose W is still to come
    test_name = "atomic_behind_write";
    r = rand_word();
    word = r[23:16];
    len = r[31:29];
    prepare_burst();
    expect_write(r[27:24], word, len, 6'd0);
    atop = make_atop(ATOP_LOAD, r[3:0]);
    expect_write(r[11:8], r[19:12], r[7:5], atop);
    send_aw(r[27:24], word, len, 6'd0);
    send_aw(r[11:8], r[19:12], r[7:5], atop);
    send_w(len);
    prepare_burst();
    send_w(r[7:5]);
    wait_idle();
    read_txn(r[27:24], word, len);

    test_name = "random_mix";
    stall_en = 1'b1;
    for (int n = 0; n < NumRandom; n++) begin
      r = rand_word();
      if (r[13:12] == 2'd0) begin
        prepare_burst();
        write_txn(r[27:24], r[23:16], r[31:29], 6'd0);
      end else if (r[13:12] == 2'd1) begin
        prepare_burst();
        atop = make_atop((r[11:10] == ATOP_NONE) ? ATOP_STORE : r[11:10], r[3:0]);
        write_txn(r[27:24], r[23:16], r[31:29], atop);
      end else begin
        read_txn(r[27:24], r[23:16], r[31:29]);
      end
    end
    stall_en = 1'b0;
    // A few idle cycles let stray responses reach the compare process
    repeat (4) @(posedge clk_i);

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== atop_filter.f ====
src/atop_filter_pkg.sv
src/atop_cmd_if.sv
src/atop_write_fsm.sv
src/atop_burst_counter.sv
src/atop_r_injector.sv
src/atop_mem_slave.sv
src/atop_filter_top.sv
bench/atop_filter_sva.sv
bench/atop_filter_tb.sv

// ==== Makefile ====
# Verilator flow for the ATOP filter testbench
VERILATOR ?= verilator
TOP       ?= atop_filter_tb
FILELIST  ?= atop_filter.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
EXE       ?= Vatop_filter_tb
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(EXE): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(EXE)

sim: $(BUILD_DIR)/$(EXE)
	-$(BUILD_DIR)/$(EXE) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
